/* design/link_cfg.svh */
// Link configuration macros
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// lane codecs in the link
`define LINK_LANES 4

// end-to-end input credits and per-lane FIFO depth
`define LINK_CREDITS 8

`endif

/* design/link_pkg.sv */
// Link shared types
`default_nettype none
`include "link_cfg.svh"

package link_pkg;

    typedef logic [7:0] byte_t;

    // code group as {fghj, abcdei}, a is bit 5 and f is bit 9
    typedef logic [9:0] sym_t;

    typedef struct packed {
        logic  k;
        byte_t data;
    } lane_word_t;

    // decoded word with its receive error flags
    typedef struct packed {
        lane_word_t w;
        logic       code_err;
        logic       disp_err;
    } rx_word_t;

    typedef logic [$clog2(`LINK_LANES)-1:0] lane_idx_t;

    // substitute for control bytes outside the K code set
    localparam byte_t K28_5 = 8'hBC;

endpackage

`default_nettype wire

/* design/lane_if.sv */
// Lane word interface
`default_nettype none

interface lane_if;
    import link_pkg::*;

    // single-cycle qualifier, no back-pressure
    logic      valid;
    rx_word_t  word;
    lane_idx_t lane;

    modport src (output valid, word, lane);
    modport dst (input valid, word, lane);

endinterface

`default_nettype wire

/* design/byte_striper.sv */
// Round-robin byte striper
`default_nettype none
`include "link_cfg.svh"

module byte_striper (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            in_valid,
    input  wire link_pkg::byte_t in_data,
    input  wire logic            in_k,
    lane_if.src                  lanes [`LINK_LANES]
);
    import link_pkg::*;

    lane_idx_t  wr_lane;
    lane_word_t in_word;

    assign in_word = '{k: in_k, data: in_data};

    // lane pointer advances once per accepted byte
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_lane <= '0;
        end else if (in_valid) begin
            if (wr_lane == lane_idx_t'(`LINK_LANES - 1)) begin
                wr_lane <= '0;
            end else begin
                wr_lane <= wr_lane + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `LINK_LANES; i++) begin : g_lane
        assign lanes[i].lane = lane_idx_t'(i);

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                lanes[i].valid <= 1'b0;
            end else begin
                lanes[i].valid <= in_valid && (wr_lane == lane_idx_t'(i));
            end
        end

        // error flags only carry meaning on the receive side
        always_ff @(posedge clk) begin
            if (in_valid && (wr_lane == lane_idx_t'(i))) begin
                lanes[i].word <= '{w: in_word, code_err: 1'b0, disp_err: 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* design/lane_codec.sv */
// 8b/10b lane codec
`default_nettype none

module lane_codec (
    input  wire logic           clk,
    input  wire logic           reset_n,
    lane_if.dst                 tx,
    output link_pkg::sym_t      tx_sym,
    output logic                tx_sym_valid,
    input  wire link_pkg::sym_t rx_sym,
    input  wire logic           rx_sym_valid,
    lane_if.src                 rx
);
    import link_pkg::*;

    // 5b/6b codes for negative disparity, abcdei
    localparam logic [5:0] ENC6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // 3b/4b data codes, primary x.7
    localparam logic [3:0] ENC4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    // 3b/4b control codes when the 6b sub-block leaves disparity negative
    localparam logic [3:0] K4 [8] = '{
        4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
    };

    function automatic logic sub_rd(input int ones, input int half, input logic rd);
        if (ones > half) return 1'b1;
        if (ones < half) return 1'b0;
        return rd;
    endfunction

    // unbalanced codes and the D.7 / x.3 specials have a complement form
    function automatic logic has_alt6(input logic [5:0] c);
        return ($countones(c) != 3) || (c == 6'b111000);
    endfunction

    function automatic logic has_alt4(input logic [3:0] c);
        return ($countones(c) != 2) || (c == 4'b1100);
    endfunction

    function automatic logic k_legal(input byte_t b);
        return (b[4:0] == 5'd28) || (b inside {8'hF7, 8'hFB, 8'hFD, 8'hFE});
    endfunction

    // {hit, edcba}
    function automatic logic [5:0] dec6(input logic [5:0] s);
        logic [5:0] r;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            if (s == ENC6[i] || (has_alt6(ENC6[i]) && s == ~ENC6[i])) begin
                r = {1'b1, 5'(i)};
            end
        end
        return r;
    endfunction

    // {hit, alternate x.7, hgf}
    function automatic logic [4:0] dec4(input logic [3:0] s);
        logic [4:0] r;
        r = '0;
        for (int j = 0; j < 8; j++) begin
            if (s == ENC4[j] || (has_alt4(ENC4[j]) && s == ~ENC4[j])) begin
                r = {2'b10, 3'(j)};
            end
        end
        if (s == 4'b0111 || s == 4'b1000) begin
            r = {2'b11, 3'd7};
        end
        return r;
    endfunction

    // {hit, hgf} for K.28 under the disparity left by its 6b sub-block
    function automatic logic [3:0] deck4(input logic [3:0] s, input logic rd_mid);
        logic [3:0] r;
        r = '0;
        for (int j = 0; j < 8; j++) begin
            if (s == (rd_mid ? ~K4[j] : K4[j])) begin
                r = {1'b1, 3'(j)};
            end
        end
        return r;
    endfunction

    // encoder, disparity 1 means positive
    logic       enc_rd;
    logic       enc_rd_mid;
    logic       enc_rd_next;
    logic       enc_k;
    logic       enc_a7;
    byte_t      enc_byte;
    logic [5:0] enc_c6;
    logic [3:0] enc_c4;
    lane_idx_t  lane_id;

    // decoder
    logic       dec_rd;
    logic       dec_rd_mid;
    logic       dec_rd_next;
    int         ones6;
    int         ones4;
    logic [5:0] dec_x;
    logic [4:0] dec_y;
    logic [3:0] dec_ky;
    logic       dec_k;
    logic       dec_code_err;
    logic       dec_disp_err;
    byte_t      dec_byte;

    always_comb begin
        enc_k    = tx.word.w.k;
        enc_byte = tx.word.w.data;
        if (enc_k && !k_legal(enc_byte)) begin
            enc_byte = K28_5;
        end
        enc_c6 = (enc_k && enc_byte[4:0] == 5'd28) ? 6'b001111 : ENC6[enc_byte[4:0]];
        if (enc_rd && has_alt6(enc_c6)) begin
            enc_c6 = ~enc_c6;
        end
        enc_rd_mid = sub_rd($countones(enc_c6), 3, enc_rd);
        // alternate x.7 avoids a run of five
        enc_a7 = (enc_byte[7:5] == 3'd7) &&
                 (enc_rd_mid ? (enc_byte[4:0] inside {5'd11, 5'd13, 5'd14})
                             : (enc_byte[4:0] inside {5'd17, 5'd18, 5'd20}));
        if (enc_k) begin
            enc_c4 = enc_rd_mid ? ~K4[enc_byte[7:5]] : K4[enc_byte[7:5]];
        end else begin
            enc_c4 = enc_a7 ? 4'b0111 : ENC4[enc_byte[7:5]];
            if (enc_rd_mid && has_alt4(enc_c4)) begin
                enc_c4 = ~enc_c4;
            end
        end
        enc_rd_next = sub_rd($countones(enc_c4), 2, enc_rd_mid);
    end

    always_comb begin
        ones6        = $countones(rx_sym[5:0]);
        ones4        = $countones(rx_sym[9:6]);
        dec_rd_mid   = sub_rd(ones6, 3, dec_rd);
        dec_rd_next  = sub_rd(ones4, 2, dec_rd_mid);
        dec_disp_err = (ones6 != 3 && ((ones6 > 3) == dec_rd)) ||
                       (ones4 != 2 && ((ones4 > 2) == dec_rd_mid));
        dec_x  = dec6(rx_sym[5:0]);
        dec_y  = dec4(rx_sym[9:6]);
        dec_ky = deck4(rx_sym[9:6], dec_rd_mid);
        if (rx_sym[5:0] == 6'b001111 || rx_sym[5:0] == 6'b110000) begin
            dec_code_err = !dec_ky[3];
            dec_k        = 1'b1;
            dec_byte     = {dec_ky[2:0], 5'd28};
        end else begin
            // alternate x.7 only after its own 6b codes or as K.23/27/29/30
            dec_code_err = !dec_x[5] || !dec_y[4] ||
                           (dec_y[3] && !(dec_x[4:0] inside {5'd11, 5'd13, 5'd14, 5'd17,
                                                             5'd18, 5'd20, 5'd23, 5'd27,
                                                             5'd29, 5'd30}));
            dec_k    = dec_y[3] && (dec_x[4:0] inside {5'd23, 5'd27, 5'd29, 5'd30});
            dec_byte = {dec_y[2:0], dec_x[4:0]};
        end
        if (dec_code_err) begin
            dec_k    = 1'b0;
            dec_byte = '0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enc_rd       <= 1'b0;
            dec_rd       <= 1'b0;
            lane_id      <= '0;
            tx_sym_valid <= 1'b0;
            rx.valid     <= 1'b0;
        end else begin
            tx_sym_valid <= tx.valid;
            rx.valid     <= rx_sym_valid;
            if (tx.valid) begin
                enc_rd  <= enc_rd_next;
                lane_id <= tx.lane;
            end
            // disparity follows the received bits even after a code error
            if (rx_sym_valid) begin
                dec_rd <= dec_rd_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx.valid) begin
            tx_sym <= {enc_c4, enc_c6};
        end
        if (rx_sym_valid) begin
            rx.word <= '{w: '{k: dec_k, data: dec_byte},
                         code_err: dec_code_err,
                         disp_err: dec_disp_err};
            rx.lane <= lane_id;
        end
    end

endmodule

`default_nettype wire

/* design/symbol_merger.sv */
// In-order lane merger
`default_nettype none
`include "link_cfg.svh"

module symbol_merger (
    input  wire logic       clk,
    input  wire logic       reset_n,
    lane_if.dst             lanes [`LINK_LANES],
    output logic            out_valid,
    output link_pkg::byte_t out_data,
    output logic            out_k,
    output logic            out_code_err,
    output logic            out_disp_err,
    input  wire logic       out_credit,
    output logic            in_credit_return
);
    import link_pkg::*;

    localparam int AW = $clog2(`LINK_CREDITS);

    logic [`LINK_LANES-1:0] wr_valid;
    rx_word_t               wr_word [`LINK_LANES];
    lane_idx_t              wr_lane [`LINK_LANES];
    rx_word_t               mem [`LINK_LANES][`LINK_CREDITS];
    logic [AW:0]            wptr [`LINK_LANES];
    logic [AW:0]            rptr [`LINK_LANES];
    lane_idx_t              rd_lane;
    // output credits held, saturating
    logic [15:0]            credits;
    rx_word_t               head;
    logic                   fire;

    for (genvar i = 0; i < `LINK_LANES; i++) begin : g_in
        assign wr_valid[i] = lanes[i].valid;
        assign wr_word[i]  = lanes[i].word;
        assign wr_lane[i]  = lanes[i].lane;
    end

    // read pointer walks the lanes in striper order
    assign head = mem[rd_lane][rptr[rd_lane][AW-1:0]];
    assign fire = (rptr[rd_lane] != wptr[rd_lane]) && (credits != '0);

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LINK_LANES; i++) begin
            if (wr_valid[i]) begin
                mem[wr_lane[i]][wptr[wr_lane[i]][AW-1:0]] <= wr_word[i];
            end
        end
        if (fire) begin
            out_data <= head.w.data;
            out_k    <= head.w.k;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `LINK_LANES; i++) begin
                wptr[i] <= '0;
                rptr[i] <= '0;
            end
            rd_lane          <= '0;
            credits          <= '0;
            out_valid        <= 1'b0;
            out_code_err     <= 1'b0;
            out_disp_err     <= 1'b0;
            in_credit_return <= 1'b0;
        end else begin
            for (int i = 0; i < `LINK_LANES; i++) begin
                if (wr_valid[i]) begin
                    wptr[wr_lane[i]] <= wptr[wr_lane[i]] + 1'b1;
                end
            end
            if (fire) begin
                rptr[rd_lane] <= rptr[rd_lane] + 1'b1;
                rd_lane <= (rd_lane == lane_idx_t'(`LINK_LANES - 1)) ? '0 : rd_lane + 1'b1;
            end
            if (out_credit && !fire && credits != '1) begin
                credits <= credits + 1'b1;
            end else if (fire && !out_credit) begin
                credits <= credits - 1'b1;
            end
            // each byte out frees one end-to-end input credit
            out_valid        <= fire;
            in_credit_return <= fire;
            out_code_err     <= fire && head.code_err;
            out_disp_err     <= fire && head.disp_err;
        end
    end

endmodule

`default_nettype wire

/* design/link_top.sv */
// 8b/10b link endpoint top
`default_nettype none
`include "link_cfg.svh"

module link_top (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     in_valid,
    input  wire link_pkg::byte_t          in_data,
    input  wire logic                     in_k,
    output logic                          in_credit_return,
    output logic                          out_valid,
    output link_pkg::byte_t               out_data,
    output logic                          out_k,
    output logic                          out_code_err,
    output logic                          out_disp_err,
    input  wire logic                     out_credit,
    output logic [`LINK_LANES*10-1:0]     tx_syms,
    output logic [`LINK_LANES-1:0]        tx_sym_valids,
    input  wire logic [`LINK_LANES*10-1:0] rx_syms,
    input  wire logic [`LINK_LANES-1:0]   rx_sym_valids
);

    // striper to codecs and codecs to merger
    lane_if tx_lanes [`LINK_LANES] ();
    lane_if rx_lanes [`LINK_LANES] ();

    byte_striper u_striper (
        .clk     (clk),
        .reset_n (reset_n),
        .in_valid(in_valid),
        .in_data (in_data),
        .in_k    (in_k),
        .lanes   (tx_lanes)
    );

    for (genvar i = 0; i < `LINK_LANES; i++) begin : g_lane
        lane_codec u_codec (
            .clk         (clk),
            .reset_n     (reset_n),
            .tx          (tx_lanes[i]),
            .tx_sym      (tx_syms[i*10 +: 10]),
            .tx_sym_valid(tx_sym_valids[i]),
            .rx_sym      (rx_syms[i*10 +: 10]),
            .rx_sym_valid(rx_sym_valids[i]),
            .rx          (rx_lanes[i])
        );
    end

    symbol_merger u_merger (
        .clk             (clk),
        .reset_n         (reset_n),
        .lanes           (rx_lanes),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_k           (out_k),
        .out_code_err    (out_code_err),
        .out_disp_err    (out_disp_err),
        .out_credit      (out_credit),
        .in_credit_return(in_credit_return)
    );

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
// Link endpoint checker
`default_nettype none
`include "link_cfg.svh"

module tb_checker (
    input wire logic                          clk,
    input wire logic                          reset_n,
    input wire logic                          in_valid,
    input wire link_pkg::byte_t               in_data,
    input wire logic                          in_k,
    input wire logic                          in_credit_return,
    input wire logic [`LINK_LANES*10-1:0]     tx_syms,
    input wire logic [`LINK_LANES-1:0]        tx_sym_valids,
    input wire logic [`LINK_LANES*10-1:0]     rx_syms,
    input wire logic [`LINK_LANES-1:0]        rx_sym_valids,
    input wire logic                          out_valid,
    input wire link_pkg::byte_t               out_data,
    input wire logic                          out_k,
    input wire logic                          out_code_err,
    input wire logic                          out_disp_err,
    input wire logic                          out_credit
);
    import link_pkg::*;

    localparam int MAX_BYTES = 1024;

    // 5b/6b in the RD- column, written abcdei
    localparam logic [5:0] SIX_B [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // 3b/4b in the RD- column, fghj, x.7 primary
    localparam logic [3:0] FOUR_B [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    // K.28 3b/4b following 110000
    localparam logic [3:0] K28_FOUR [8] = '{
        4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
    };

    int         errors = 0;
    int         test_errors = 0;
    int         tests = 0;
    int         in_count = 0;
    int         out_count = 0;
    int         out_mark = 0;
    int         code_seen = 0;
    int         disp_seen = 0;
    // output credits granted by the sink so far
    int         grants = 0;
    lane_word_t sent_words [MAX_BYTES];
    logic       exp_cerr [MAX_BYTES];
    logic       exp_derr [MAX_BYTES];
    logic       decoded [MAX_BYTES];
    int         tx_cnt [`LINK_LANES];
    int         rx_cnt [`LINK_LANES];
    // model running disparity per lane, 1 is positive
    logic       enc_rd [`LINK_LANES];
    logic       dec_rd [`LINK_LANES];
    // expected tx symbol strobes, two cycles behind the input
    logic [`LINK_LANES-1:0] tv_pipe [2];

    initial begin
        for (int i = 0; i < `LINK_LANES; i++) begin
            tx_cnt[i] = 0;
            rx_cnt[i] = 0;
            enc_rd[i] = 1'b0;
            dec_rd[i] = 1'b0;
        end
        for (int n = 0; n < MAX_BYTES; n++) begin
            decoded[n] = 1'b0;
        end
        tv_pipe[0] = '0;
        tv_pipe[1] = '0;
    end

    function automatic logic blk_rd(input int ones, input int bal, input logic rd);
        logic r;
        r = rd;
        if (ones > bal) begin
            r = 1'b1;
        end else if (ones < bal) begin
            r = 1'b0;
        end
        return r;
    endfunction

    // reference encoder, returns {next disparity, fghj, abcdei}
    function automatic logic [10:0] ref_encode(input byte_t b, input logic k, input logic rd);
        byte_t      v;
        logic [5:0] s6;
        logic [3:0] s4;
        logic       mid;
        logic       alt7;
        v = b;
        if (k && v[4:0] != 5'd28 && !(v inside {8'hF7, 8'hFB, 8'hFD, 8'hFE})) begin
            v = 8'hBC;
        end
        s6 = (k && v[4:0] == 5'd28) ? 6'b001111 : SIX_B[v[4:0]];
        if (rd && ($countones(s6) != 3 || s6 == 6'b111000)) begin
            s6 = ~s6;
        end
        mid = blk_rd($countones(s6), 3, rd);
        alt7 = (v[7:5] == 3'd7) &&
               (k || (mid ? (v[4:0] inside {5'd11, 5'd13, 5'd14})
                          : (v[4:0] inside {5'd17, 5'd18, 5'd20})));
        if (k && v[4:0] == 5'd28) begin
            s4 = mid ? ~K28_FOUR[v[7:5]] : K28_FOUR[v[7:5]];
        end else begin
            s4 = alt7 ? 4'b0111 : FOUR_B[v[7:5]];
            if (mid && ($countones(s4) != 2 || s4 == 4'b1100)) begin
                s4 = ~s4;
            end
        end
        return {blk_rd($countones(s4), 2, mid), s4, s6};
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("failure: %s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d bytes out, %0d errors", tests, name,
                 out_count - out_mark, test_errors);
        out_mark = out_count;
        test_errors = 0;
    endtask

    task automatic summary();
        $display("tests %0d, bytes in %0d, bytes out %0d, errors %0d",
                 tests, in_count, out_count, errors);
    endtask

    always @(posedge clk) begin
        int         seq;
        sym_t       s;
        logic [10:0] r;
        logic [10:0] e0;
        logic [10:0] e1;
        int         o6;
        int         o4;
        logic       mid;
        logic       derr;
        lane_word_t w;
        if (reset_n) begin
            // symbols leave a fixed two cycles after their byte
            if (tx_sym_valids !== tv_pipe[1]) begin
                report_error($sformatf("tx_sym_valids %b, expected %b",
                                       tx_sym_valids, tv_pipe[1]));
            end
            tv_pipe[1] = tv_pipe[0];
            tv_pipe[0] = '0;
            if (in_valid) begin
                tv_pipe[0][in_count % `LINK_LANES] = 1'b1;
                sent_words[in_count] = '{k: in_k, data: in_data};
                in_count++;
            end
            for (int i = 0; i < `LINK_LANES; i++) begin
                if (tx_sym_valids[i] === 1'b1) begin
                    seq = tx_cnt[i] * `LINK_LANES + i;
                    tx_cnt[i]++;
                    s = tx_syms[i*10 +: 10];
                    w = sent_words[seq];
                    r = ref_encode(w.data, w.k, enc_rd[i]);
                    if (s !== r[9:0]) begin
                        report_error($sformatf("lane %0d byte %0d tx symbol %b, expected %b",
                                               i, seq, s, r[9:0]));
                    end
                    if ($countones(s) < 4 || $countones(s) > 6) begin
                        report_error($sformatf("lane %0d tx symbol %b is unbalanced", i, s));
                    end
                    enc_rd[i] = r[10];
                end
                // receive side follows the looped back bits
                if (rx_sym_valids[i] === 1'b1) begin
                    seq = rx_cnt[i] * `LINK_LANES + i;
                    rx_cnt[i]++;
                    s = rx_syms[i*10 +: 10];
                    w = sent_words[seq];
                    o6 = $countones(s[5:0]);
                    o4 = $countones(s[9:6]);
                    derr = (o6 > 3 && dec_rd[i]) || (o6 < 3 && !dec_rd[i]);
                    mid = blk_rd(o6, 3, dec_rd[i]);
                    derr = derr || (o4 > 2 && mid) || (o4 < 2 && !mid);
                    dec_rd[i] = blk_rd(o4, 2, mid);
                    e0 = ref_encode(w.data, w.k, 1'b0);
                    e1 = ref_encode(w.data, w.k, 1'b1);
                    exp_cerr[seq] = (s != e0[9:0]) && (s != e1[9:0]);
                    exp_derr[seq] = derr;
                    decoded[seq] = 1'b1;
                end
            end
            // every byte out must be backed by an earlier grant
            if (out_valid === 1'b1 && out_count >= grants) begin
                report_error($sformatf("byte %0d out with no output credit held", out_count));
            end
            grants += int'(out_credit === 1'b1);
            if (out_valid === 1'b1) begin
                if (out_count >= in_count || !decoded[out_count]) begin
                    note_failure($sformatf("byte came out with no byte expected, count %0d",
                                           out_count));
                end else begin
                    w = sent_words[out_count];
                    if (exp_cerr[out_count]) begin
                        w = '0;
                    end
                    if (out_data !== w.data || out_k !== w.k) begin
                        report_error($sformatf("byte %0d out %h k %b, expected %h k %b",
                                               out_count, out_data, out_k, w.data, w.k));
                    end
                    if (out_code_err !== exp_cerr[out_count] ||
                        out_disp_err !== exp_derr[out_count]) begin
                        report_error($sformatf("byte %0d flags code %b disp %b, expected %b %b",
                                               out_count, out_code_err, out_disp_err,
                                               exp_cerr[out_count], exp_derr[out_count]));
                    end
                end
                code_seen += int'(out_code_err === 1'b1);
                disp_seen += int'(out_disp_err === 1'b1);
                out_count++;
            end
            if (in_credit_return !== out_valid) begin
                report_error($sformatf("in_credit_return %b with out_valid %b",
                                       in_credit_return, out_valid));
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
// Link endpoint testbench
`default_nettype none
`include "link_cfg.svh"

module tb_top;
    import link_pkg::*;

    localparam int TOTAL_BYTES = 256 + 24 + 64 + 16 + 16 + 100;
    localparam int CYCLE_LIMIT = 40 * TOTAL_BYTES + 200;
    localparam byte_t K_CODES [12] = '{
        8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
    };

    logic                       clk;
    logic                       reset_n;
    logic                       in_valid;
    byte_t                      in_data;
    logic                       in_k;
    logic                       in_credit_return;
    logic                       out_valid;
    byte_t                      out_data;
    logic                       out_k;
    logic                       out_code_err;
    logic                       out_disp_err;
    logic                       out_credit;
    logic [`LINK_LANES*10-1:0]  tx_syms;
    logic [`LINK_LANES-1:0]     tx_sym_valids;
    logic [`LINK_LANES*10-1:0]  rx_syms;
    logic [`LINK_LANES-1:0]     rx_sym_valids;

    int   seed_val;
    int   sent_total = 0;
    int   returned = 0;
    int   granted = 0;
    int   emitted = 0;
    int   cycles = 0;
    int   hold = 0;
    int   mark;
    logic bursty;
    // 0 clean, 1 opposite disparity, 2 all zeros
    int   corrupt_mode [1024];
    int   lb_cnt [`LINK_LANES];

    link_top dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_k            (in_k),
        .in_credit_return(in_credit_return),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_k           (out_k),
        .out_code_err    (out_code_err),
        .out_disp_err    (out_disp_err),
        .out_credit      (out_credit),
        .tx_syms         (tx_syms),
        .tx_sym_valids   (tx_sym_valids),
        .rx_syms         (rx_syms),
        .rx_sym_valids   (rx_sym_valids)
    );

    tb_checker chk (
        .clk             (clk),
        .reset_n         (reset_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_k            (in_k),
        .in_credit_return(in_credit_return),
        .tx_syms         (tx_syms),
        .tx_sym_valids   (tx_sym_valids),
        .rx_syms         (rx_syms),
        .rx_sym_valids   (rx_sym_valids),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_k           (out_k),
        .out_code_err    (out_code_err),
        .out_disp_err    (out_disp_err),
        .out_credit      (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // source side, one byte per held credit
    task automatic send_byte(input byte_t b, input logic k, input int mode);
        while (sent_total - returned >= `LINK_CREDITS) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data <= b;
        in_k <= k;
        corrupt_mode[sent_total] = mode;
        sent_total++;
        @(posedge clk);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        while (chk.out_count < sent_total) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // loopback with optional corruption
    always @(posedge clk) begin
        int mode;
        for (int i = 0; i < `LINK_LANES; i++) begin
            mode = 0;
            if (tx_sym_valids[i] === 1'b1) begin
                mode = corrupt_mode[lb_cnt[i] * `LINK_LANES + i];
                lb_cnt[i]++;
            end
            if (mode == 1) begin
                rx_syms[i*10 +: 10] <= ~tx_syms[i*10 +: 10];
            end else if (mode == 2) begin
                rx_syms[i*10 +: 10] <= '0;
            end else begin
                rx_syms[i*10 +: 10] <= tx_syms[i*10 +: 10];
            end
        end
        rx_sym_valids <= reset_n ? tx_sym_valids : '0;
    end

    // credit bookkeeping and output credit grants
    always @(posedge clk) begin
        logic grant;
        grant = 1'b0;
        if (in_credit_return === 1'b1) begin
            returned <= returned + 1;
        end
        if (out_valid === 1'b1) begin
            emitted <= emitted + 1;
        end
        if (!reset_n) begin
            grant = 1'b0;
        end else if (bursty && hold > 0) begin
            hold <= hold - 1;
        end else if (bursty && $urandom % 6 == 0) begin
            hold <= $urandom % 30;
        end else begin
            grant = (granted - emitted) < (bursty ? 2 : 16);
        end
        out_credit <= grant;
        granted <= granted + int'(grant);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: output stalled, %0d of %0d bytes out after %0d cycles",
                     chk.out_count, sent_total, cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        seed_val = $urandom(75144);
        for (int i = 0; i < `LINK_LANES; i++) begin
            lb_cnt[i] = 0;
        end
        reset_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_k = 1'b0;
        out_credit = 1'b0;
        rx_syms = '0;
        rx_sym_valids = '0;
        bursty = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        for (int v = 0; v < 256; v++) begin
            send_byte(byte_t'(v), 1'b0, 0);
        end
        drain();
        chk.end_test("data round trip");

        for (int n = 0; n < 12; n++) begin
            send_byte(K_CODES[n], 1'b1, 0);
            send_byte(byte_t'($urandom), 1'b0, 0);
        end
        drain();
        chk.end_test("control codes");

        for (int n = 0; n < 64; n++) begin
            if ($urandom % 4 == 0) begin
                send_byte(K_CODES[$urandom % 12], 1'b1, 0);
            end else begin
                send_byte(byte_t'($urandom), 1'b0, 0);
            end
        end
        drain();
        chk.end_test("transmit disparity");

        // D.0.0 complements fully into its alternate
        mark = chk.disp_seen;
        for (int n = 0; n < 16; n++) begin
            send_byte((n == 5) ? 8'h00 : byte_t'($urandom), 1'b0, (n == 5) ? 1 : 0);
        end
        drain();
        if (chk.disp_seen == mark) begin
            chk.note_failure("opposite disparity symbol gave no disparity error");
        end
        chk.end_test("disparity error");

        mark = chk.code_seen;
        for (int n = 0; n < 16; n++) begin
            send_byte(byte_t'($urandom), 1'b0, (n == 6) ? 2 : 0);
        end
        drain();
        if (chk.code_seen == mark) begin
            chk.note_failure("all zero symbol gave no code error");
        end
        chk.end_test("code error");

        bursty <= 1'b1;
        for (int n = 0; n < 100; n++) begin
            send_byte(byte_t'($urandom), 1'b0, 0);
        end
        drain();
        chk.end_test("back-pressure");

        repeat (20) @(posedge clk);
        if (chk.out_count != sent_total || returned != sent_total) begin
            chk.note_failure($sformatf("%0d bytes sent but %0d out and %0d credits returned",
                                       sent_total, chk.out_count, returned));
        end
        chk.summary();
        if (chk.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/link_pkg.sv
design/lane_if.sv
design/byte_striper.sv
design/lane_codec.sv
design/symbol_merger.sv
design/link_top.sv
tb/tb_checker.sv
tb/tb_top.sv
